/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exu_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* alu/alu.sv */
`timescale 1ns/1ns
`default_nettype none
`include "exu_config.svh"

module alu (
    input  exu_pkg::uop_t  uop_i,
    input  exu_pkg::word_t rdata0_i,
    input  exu_pkg::word_t rdata1_i,
    input  exu_pkg::fwd_e  fwd0_i,
    input  exu_pkg::fwd_e  fwd1_i,
    input  exu_pkg::wb_t   wb_fwd_i,
    input  exu_pkg::wb_t   ret_fwd_i,
    input  exu_pkg::word_t cp0_rdata_i,
    output logic [4:0]     cp0_addr_o,
    output logic           cp0_wen_o,
    output exu_pkg::word_t cp0_wdata_o,
    output exu_pkg::word_t result_o,
    output exu_pkg::exc_e  exc_o,
    output exu_pkg::br_t   br_o
);
    import exu_pkg::*;

    localparam int MSB = `EXU_XLEN - 1;

    word_t      src0;
    word_t      src1;
    word_t      logic_res;
    word_t      shift_res;
    word_t      arith_res;
    word_t      count_res;
    word_t      addend;
    word_t      sum;
    logic [4:0] shamt;
    logic       is_sub;
    logic       overflow;
    logic       taken;

    function automatic word_t fwd_mux(input fwd_e sel, input word_t rf,
                                      input wb_t w, input wb_t r);
        case (sel)
            FWD_WB_STAGE:     return w.wdata;
            FWD_RETIRE_STAGE: return r.wdata;
            default:          return rf;
        endcase
    endfunction

    // run length of 'ones' from the msb down
    function automatic word_t lead_count(input word_t val, input logic ones);
        word_t cnt;
        logic  stop;
        cnt  = '0;
        stop = 1'b0;
        for (int i = MSB; i >= 0; i--) begin
            if (!stop && val[i] == ones) begin
                cnt = cnt + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
        return cnt;
    endfunction

    assign src0 = uop_i.src0_re ? fwd_mux(fwd0_i, rdata0_i, wb_fwd_i, ret_fwd_i) : uop_i.imm;
    assign src1 = uop_i.src1_re ? fwd_mux(fwd1_i, rdata1_i, wb_fwd_i, ret_fwd_i) : uop_i.imm;

    always_comb begin
        case (uop_i.op)
            OP_AND:         logic_res = src0 & src1;
            OP_OR, OP_LUI:  logic_res = src0 | src1;  // lui imm arrives pre-shifted
            OP_XOR:         logic_res = src0 ^ src1;
            OP_NOR:         logic_res = ~(src0 | src1);
            default:        logic_res = '0;
        endcase
    end

    assign shamt = src0[4:0];

    always_comb begin
        case (uop_i.op)
            OP_SLL, OP_SLLV: shift_res = src1 << shamt;
            OP_SRL, OP_SRLV: shift_res = src1 >> shamt;
            OP_SRA, OP_SRAV: shift_res = $signed(src1) >>> shamt;
            default:         shift_res = '0;
        endcase
    end

    assign is_sub = (uop_i.op == OP_SUB) || (uop_i.op == OP_SUBU);
    assign addend = is_sub ? ~src1 : src1;
    assign sum    = src0 + addend + word_t'(is_sub);

    // same-sign inputs, sign flipped
    assign overflow = (uop_i.group == GRP_ARITH)
                   && (uop_i.op == OP_ADD || uop_i.op == OP_SUB)
                   && (src0[MSB] == addend[MSB]) && (sum[MSB] != src0[MSB]);

    always_comb begin
        case (uop_i.op)
            OP_SLT:  arith_res = word_t'($signed(src0) < $signed(src1));
            OP_SLTU: arith_res = word_t'(src0 < src1);
            default: arith_res = sum;
        endcase
    end

    assign count_res = lead_count(src0, uop_i.op == OP_CLO);

    always_comb begin
        case (uop_i.op)
            OP_BEQ:  taken = (src0 == src1);
            OP_BNE:  taken = (src0 != src1);
            OP_BGEZ: taken = !src0[MSB];
            OP_BGTZ: taken = !src0[MSB] && (src0 != '0);
            OP_BLEZ: taken = src0[MSB] || (src0 == '0);
            OP_BLTZ: taken = src0[MSB];
            OP_J, OP_JR, OP_JAL, OP_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign br_o.taken  = uop_i.is_branch && taken;
    assign br_o.target = (uop_i.op == OP_JR || uop_i.op == OP_JALR) ? src0 : uop_i.pred_addr;

    assign cp0_addr_o  = uop_i.cp0_addr;
    assign cp0_wen_o   = (uop_i.op == OP_MTC0);
    assign cp0_wdata_o = src0;

    // earlier exception keeps its code
    assign exc_o = (uop_i.exc_in != EXC_NONE) ? uop_i.exc_in :
                   overflow                   ? EXC_INT_OVERFLOW : EXC_NONE;

    always_comb begin
        case (uop_i.group)
            GRP_LOGIC:  result_o = logic_res;
            GRP_SHIFT:  result_o = shift_res;
            GRP_ARITH:  result_o = arith_res;
            GRP_MOVE:   result_o = src0;
            GRP_COUNT:  result_o = count_res;
            GRP_BRANCH: result_o = uop_i.pc + word_t'(8);  // link address
            GRP_CP0:    result_o = cp0_rdata_i;
            default:    result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* common/exu_config.svh */
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

`define EXU_XLEN    32
`define EXU_PREGS   32
`define EXU_PREG_W  5

// cp0 register numbers
`define CP0_BADVADDR 8
`define CP0_COUNT    9
`define CP0_STATUS   12
`define CP0_CAUSE    13
`define CP0_EPC      14

`endif

/* common/exu_pkg.sv */
`default_nettype none
`include "exu_config.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0]   word_t;
    typedef logic [`EXU_PREG_W-1:0] preg_t;

    typedef enum logic [5:0] {
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
        OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_MOVE, OP_CLZ, OP_CLO,
        OP_BEQ, OP_BNE, OP_BGEZ, OP_BGTZ, OP_BLEZ, OP_BLTZ,
        OP_J, OP_JR, OP_JAL, OP_JALR,
        OP_MFC0, OP_MTC0
    } uop_e;

    typedef enum logic [2:0] {
        GRP_LOGIC, GRP_SHIFT, GRP_ARITH, GRP_MOVE, GRP_COUNT, GRP_BRANCH, GRP_CP0
    } alu_group_e;

    // mips cause.excode values
    typedef enum logic [4:0] {
        EXC_NONE         = 5'd0,
        EXC_RESERVED     = 5'd10,
        EXC_INT_OVERFLOW = 5'd12
    } exc_e;

    typedef enum logic [1:0] {
        FWD_REGFILE, FWD_WB_STAGE, FWD_RETIRE_STAGE
    } fwd_e;

    typedef struct packed {
        logic [5:0] id;         // rob tag
        uop_e       op;
        alu_group_e group;
        word_t      pc;
        word_t      pred_addr;  // from the predictor
        word_t      imm;
        preg_t      src0;
        preg_t      src1;
        preg_t      dst;
        logic       src0_re;
        logic       src1_re;
        logic       dst_we;
        logic       is_branch;
        logic [4:0] cp0_addr;
        exc_e       exc_in;     // raised before execute
    } uop_t;

    typedef struct packed {
        preg_t dst;
        logic  wen;
        word_t wdata;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_t;

    typedef struct packed {
        logic [5:0] id;
        exc_e       exc;
        word_t      bad_vaddr;
        br_t        br;
    } fin_t;

    // stage payloads
    typedef struct packed {
        uop_t  uop;
        word_t rdata0;
        word_t rdata1;
    } x_pld_t;

    typedef struct packed {
        wb_t  wb;
        fin_t fin;
    } w_pld_t;

endpackage

`default_nettype wire

/* compile.f */
+incdir+common
common/exu_pkg.sv
rtl/stage_reg.sv
rtl/prf.sv
rtl/cp0_regs.sv
rtl/fwd_ctrl.sv
alu/alu.sv
rtl/exu_top.sv
sim/tb_exu_top.sv

/* rtl/cp0_regs.sv */
`timescale 1ns/1ns
`default_nettype none
`include "exu_config.svh"

module cp0_regs (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic [4:0]     addr_i,
    input  logic           wen_i,
    input  exu_pkg::word_t wdata_i,
    output exu_pkg::word_t rdata_o,
    input  logic           exc_i,
    input  exu_pkg::exc_e  exc_code_i,
    input  exu_pkg::word_t exc_pc_i
);
    import exu_pkg::*;

    word_t status_q;
    word_t epc_q;
    word_t badvaddr_q;
    word_t count_q;
    exc_e  cause_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            status_q   <= '0;
            epc_q      <= '0;
            badvaddr_q <= '0;
            count_q    <= '0;
            cause_q    <= EXC_NONE;
        end else begin
            count_q <= count_q + 1'b1;  // free running
            if (exc_i) begin
                cause_q    <= exc_code_i;
                epc_q      <= exc_pc_i;
                badvaddr_q <= exc_pc_i;
            end else if (wen_i) begin
                if (addr_i == `CP0_STATUS) status_q <= wdata_i;
                if (addr_i == `CP0_EPC)    epc_q    <= wdata_i;
            end
        end
    end

    always_comb begin
        case (addr_i)
            `CP0_STATUS:   rdata_o = status_q;
            `CP0_CAUSE:    rdata_o = word_t'({cause_q, 2'b00});  // excode at bits 6:2
            `CP0_EPC:      rdata_o = epc_q;
            `CP0_BADVADDR: rdata_o = badvaddr_q;
            `CP0_COUNT:    rdata_o = count_q;
            default:       rdata_o = '0;
        endcase
    end

    // capture always brings a real code
    a_capture: assert property (@(posedge clk_i) disable iff (rst_i)
        exc_i |-> exc_code_i != EXC_NONE);

endmodule

`default_nettype wire

/* rtl/exu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module exu_top (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           issue_valid_i,
    input  exu_pkg::uop_t  issue_uop_i,
    output exu_pkg::wb_t   wb_o,
    output logic           fin_valid_o,
    output exu_pkg::fin_t  fin_o,
    output logic           exc_valid_o,
    output exu_pkg::exc_e  exc_code_o
);
    import exu_pkg::*;

    word_t      i_rdata0;
    word_t      i_rdata1;
    x_pld_t     i_pld;
    x_pld_t     x_pld;
    logic       x_valid;
    w_pld_t     x_rec;
    w_pld_t     w_pld;
    logic       w_valid;
    fwd_e       fwd0;
    fwd_e       fwd1;
    wb_t        retire;
    logic       kill_x;
    logic       x_wen;
    word_t      x_result;
    exc_e       x_exc;
    br_t        x_br;
    logic [4:0] cp0_addr;
    logic       cp0_wen;
    word_t      cp0_wdata;
    word_t      cp0_rdata;

    assign i_pld = '{uop: issue_uop_i, rdata0: i_rdata0, rdata1: i_rdata1};

    assign x_rec = '{
        wb:  '{dst: x_pld.uop.dst, wen: x_wen, wdata: x_result},
        fin: '{id: x_pld.uop.id, exc: x_exc, bad_vaddr: x_pld.uop.pc, br: x_br}
    };

    assign wb_o        = w_pld.wb;
    assign fin_valid_o = w_valid;
    assign fin_o       = w_pld.fin;
    assign exc_code_o  = w_pld.fin.exc;

    prf u_prf (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .raddr0_i (issue_uop_i.src0),
        .raddr1_i (issue_uop_i.src1),
        .rdata0_o (i_rdata0),
        .rdata1_o (i_rdata1),
        .wr_i     (w_pld.wb)
    );

    stage_reg #(.payload_t(x_pld_t)) u_x_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .kill_i  (1'b0),
        .valid_i (issue_valid_i),
        .data_i  (i_pld),
        .valid_o (x_valid),
        .data_o  (x_pld)
    );

    alu u_alu (
        .uop_i       (x_pld.uop),
        .rdata0_i    (x_pld.rdata0),
        .rdata1_i    (x_pld.rdata1),
        .fwd0_i      (fwd0),
        .fwd1_i      (fwd1),
        .wb_fwd_i    (w_pld.wb),
        .ret_fwd_i   (retire),
        .cp0_rdata_i (cp0_rdata),
        .cp0_addr_o  (cp0_addr),
        .cp0_wen_o   (cp0_wen),
        .cp0_wdata_o (cp0_wdata),
        .result_o    (x_result),
        .exc_o       (x_exc),
        .br_o        (x_br)
    );

    fwd_ctrl u_fwd_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .x_valid_i   (x_valid),
        .x_uop_i     (x_pld.uop),
        .x_exc_i     (x_exc),
        .w_valid_i   (w_valid),
        .w_wb_i      (w_pld.wb),
        .fwd0_o      (fwd0),
        .fwd1_o      (fwd1),
        .retire_o    (retire),
        .kill_x_o    (kill_x),
        .wen_o       (x_wen),
        .exc_valid_o (exc_valid_o)
    );

    // kill drops the X uop on its way into W
    stage_reg #(.payload_t(w_pld_t)) u_w_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .kill_i  (kill_x),
        .valid_i (x_valid),
        .data_i  (x_rec),
        .valid_o (w_valid),
        .data_o  (w_pld)
    );

    cp0_regs u_cp0_regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .addr_i     (cp0_addr),
        .wen_i      (cp0_wen),
        .wdata_i    (cp0_wdata),
        .rdata_o    (cp0_rdata),
        .exc_i      (exc_valid_o),
        .exc_code_i (w_pld.fin.exc),
        .exc_pc_i   (w_pld.fin.bad_vaddr)
    );

endmodule

`default_nettype wire

/* rtl/fwd_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module fwd_ctrl (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          x_valid_i,
    input  exu_pkg::uop_t x_uop_i,
    input  exu_pkg::exc_e x_exc_i,
    input  logic          w_valid_i,
    input  exu_pkg::wb_t  w_wb_i,
    output exu_pkg::fwd_e fwd0_o,
    output exu_pkg::fwd_e fwd1_o,
    output exu_pkg::wb_t  retire_o,
    output logic          kill_x_o,
    output logic          wen_o,
    output logic          exc_valid_o
);
    import exu_pkg::*;

    wb_t  w_live;
    wb_t  retire_q;
    logic fault;
    logic exc_pend_q;

    // newest producer wins
    function automatic fwd_e pick_src(input logic re, input preg_t src,
                                      input wb_t w, input wb_t r);
        if (re && w.wen && w.dst == src) return FWD_WB_STAGE;
        if (re && r.wen && r.dst == src) return FWD_RETIRE_STAGE;
        return FWD_REGFILE;
    endfunction

    always_comb begin
        w_live     = w_wb_i;
        w_live.wen = w_valid_i && w_wb_i.wen;
    end

    assign fwd0_o = pick_src(x_uop_i.src0_re, x_uop_i.src0, w_live, retire_q);
    assign fwd1_o = pick_src(x_uop_i.src1_re, x_uop_i.src1, w_live, retire_q);

    // a faulting uop finishes but never writes
    assign wen_o = x_valid_i && x_uop_i.dst_we && (x_exc_i == EXC_NONE);
    assign fault = x_valid_i && !kill_x_o && (x_exc_i != EXC_NONE);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            retire_q   <= '0;
            exc_pend_q <= 1'b0;
        end else begin
            retire_q   <= w_live;
            exc_pend_q <= fault;
        end
    end

    assign retire_o    = retire_q;
    assign kill_x_o    = exc_pend_q;  // uop behind the fault in W is dropped
    assign exc_valid_o = exc_pend_q;

    // faulting uop sits in W without a write
    a_kill_after_fault: assert property (@(posedge clk_i) disable iff (rst_i)
        kill_x_o |-> w_valid_i && !w_wb_i.wen);

endmodule

`default_nettype wire

/* rtl/prf.sv */
`timescale 1ns/1ns
`default_nettype none
`include "exu_config.svh"

module prf (
    input  logic           clk_i,
    input  logic           rst_i,
    input  exu_pkg::preg_t raddr0_i,
    input  exu_pkg::preg_t raddr1_i,
    output exu_pkg::word_t rdata0_o,
    output exu_pkg::word_t rdata1_o,
    input  exu_pkg::wb_t   wr_i
);
    import exu_pkg::*;

    word_t regs [`EXU_PREGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `EXU_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.wen) begin
            regs[wr_i.dst] <= wr_i.wdata;
        end
    end

    // p0 is hardwired zero
    assign rdata0_o = (raddr0_i == '0) ? '0 : regs[raddr0_i];
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];

    // rename never hands out p0 as a destination
    a_no_p0_write: assert property (@(posedge clk_i) disable iff (rst_i)
        wr_i.wen |-> wr_i.dst != '0);

endmodule

`default_nettype wire

/* rtl/stage_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     kill_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        data_q <= data_i;
    end

    assign valid_o = valid_q;
    assign data_o  = valid_q ? data_q : '0;  // bubble reads as zeros

endmodule

`default_nettype wire

/* sim/tb_exu_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "exu_config.svh"

module tb_exu_top;
    import exu_pkg::*;

    localparam int N_RAND     = 300;
    localparam int N_DIRECTED = 200;  // upper bound on directed issues
    localparam int T_CLK      = 20;

    typedef struct packed {
        int    due;
        logic  wen;
        preg_t dst;
        word_t wdata;
        fin_t  fin;
        logic  exc;
    } exp_t;

    logic  clk_i;
    logic  rst_i;
    logic  issue_valid_i;
    uop_t  issue_uop_i;
    wb_t   wb_o;
    logic  fin_valid_o;
    fin_t  fin_o;
    logic  exc_valid_o;
    exc_e  exc_code_o;

    exp_t        exp_q[$];
    exp_t        exp_now;
    logic        exp_valid;
    word_t       arch [`EXU_PREGS];
    word_t       m_status;
    word_t       m_epc;
    word_t       m_badvaddr;
    exc_e        m_cause;
    logic        prev_fault;
    int          cyc;
    int          uid;
    word_t       pc_next;
    logic [31:0] seed;

    exu_top dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .issue_uop_i   (issue_uop_i),
        .wb_o          (wb_o),
        .fin_valid_o   (fin_valid_o),
        .fin_o         (fin_o),
        .exc_valid_o   (exc_valid_o),
        .exc_code_o    (exc_code_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(T_CLK / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) cyc <= cyc + 1;

    // expected record for the coming edge
    always @(negedge clk_i) begin
        if (exp_q.size() > 0 && exp_q[0].due == cyc + 1) begin
            exp_now   = exp_q.pop_front();
            exp_valid = 1'b1;
        end else begin
            exp_now   = '0;
            exp_valid = 1'b0;
        end
    end

    task automatic fail_run();
        $display("TESTS FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic mismatch(input string name, input logic [127:0] exp, input logic [127:0] got);
        $display("MISMATCH %s expected %h got %h", name, exp, got);
        fail_run();
    endtask

    a_wen: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_o.wen == (exp_valid && exp_now.wen))
        else mismatch("wb_o.wen", 128'($sampled(exp_valid && exp_now.wen)),
                      128'($sampled(wb_o.wen)));
    a_wdata: assert property (@(posedge clk_i) disable iff (rst_i)
        (exp_valid && exp_now.wen) |-> wb_o.wdata == exp_now.wdata)
        else mismatch("wb_o.wdata", 128'($sampled(exp_now.wdata)), 128'($sampled(wb_o.wdata)));
    a_wdst: assert property (@(posedge clk_i) disable iff (rst_i)
        (exp_valid && exp_now.wen) |-> wb_o.dst == exp_now.dst)
        else mismatch("wb_o.dst", 128'($sampled(exp_now.dst)), 128'($sampled(wb_o.dst)));
    a_fin_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        fin_valid_o == exp_valid)
        else mismatch("fin_valid_o", 128'($sampled(exp_valid)), 128'($sampled(fin_valid_o)));
    a_fin: assert property (@(posedge clk_i) disable iff (rst_i)
        exp_valid |-> fin_o == exp_now.fin)
        else mismatch("fin_o", 128'($sampled(exp_now.fin)), 128'($sampled(fin_o)));
    a_exc_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        exc_valid_o == (exp_valid && exp_now.exc))
        else mismatch("exc_valid_o", 128'($sampled(exp_valid && exp_now.exc)),
                      128'($sampled(exc_valid_o)));
    a_exc_code: assert property (@(posedge clk_i) disable iff (rst_i)
        (exp_valid && exp_now.exc) |-> exc_code_o == exp_now.fin.exc)
        else mismatch("exc_code_o", 128'($sampled(exp_now.fin.exc)), 128'($sampled(exc_code_o)));

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic alu_group_e group_of(input uop_e op);
        case (op)
            OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI:                    return GRP_LOGIC;
            OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV:        return GRP_SHIFT;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU:        return GRP_ARITH;
            OP_MOVE:                                                  return GRP_MOVE;
            OP_CLZ, OP_CLO:                                           return GRP_COUNT;
            OP_MFC0, OP_MTC0:                                         return GRP_CP0;
            default:                                                  return GRP_BRANCH;
        endcase
    endfunction

    // scan down from bit 31 until the run breaks
    function automatic word_t lead_run(input word_t v, input logic ones);
        for (int i = 31; i >= 0; i--) begin
            if (v[i] != ones) return word_t'(31 - i);
        end
        return 32;
    endfunction

    function automatic word_t cp0_read(input logic [4:0] addr);
        case (addr)
            `CP0_STATUS:   return m_status;
            `CP0_CAUSE:    return {25'd0, m_cause, 2'b00};
            `CP0_EPC:      return m_epc;
            `CP0_BADVADDR: return m_badvaddr;
            default:       return '0;
        endcase
    endfunction

    function automatic uop_t mk(input uop_e op, input preg_t s0, input preg_t s1,
                                input preg_t d, input word_t imm, input logic use_imm);
        uop_t u;
        u           = '0;
        u.id        = 6'(uid);
        uid++;
        u.op        = op;
        u.group     = group_of(op);
        u.pc        = pc_next;
        pc_next     = pc_next + 4;
        u.pred_addr = lcg_next() & ~32'd3;
        u.imm       = imm;
        u.src0      = s0;
        u.src1      = s1;
        u.dst       = d;
        u.src0_re   = 1'b1;
        u.src1_re   = !use_imm;
        u.is_branch = (u.group == GRP_BRANCH);
        u.exc_in    = EXC_NONE;
        case (op)
            OP_BEQ, OP_BNE, OP_BGEZ, OP_BGTZ, OP_BLEZ, OP_BLTZ, OP_J, OP_JR, OP_MTC0:
                u.dst_we = 1'b0;
            default: u.dst_we = (d != '0);
        endcase
        return u;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk_i);
            issue_valid_i = 1'b0;
            prev_fault    = 1'b0;
        end
    endtask

    task automatic issue(input uop_t u);
        word_t a;
        word_t b;
        word_t res;
        logic  taken;
        logic  ovf;
        exc_e  code;
        exp_t  e;
        @(negedge clk_i);
        issue_valid_i = 1'b1;
        issue_uop_i   = u;
        if (prev_fault) begin
            prev_fault = 1'b0;  // dropped behind the fault
            return;
        end
        a     = u.src0_re ? arch[u.src0] : u.imm;
        b     = u.src1_re ? arch[u.src1] : u.imm;
        taken = 1'b0;
        ovf   = 1'b0;
        case (u.op)
            OP_AND:           res = a & b;
            OP_OR, OP_LUI:    res = a | b;
            OP_XOR:           res = a ^ b;
            OP_NOR:           res = ~(a | b);
            OP_SLL, OP_SLLV:  res = b << a[4:0];
            OP_SRL, OP_SRLV:  res = b >> a[4:0];
            OP_SRA, OP_SRAV:  res = $signed(b) >>> a[4:0];
            OP_ADD, OP_ADDU:  res = a + b;
            OP_SUB, OP_SUBU:  res = a - b;
            OP_SLT:           res = {31'd0, $signed(a) < $signed(b)};
            OP_SLTU:          res = {31'd0, a < b};
            OP_MOVE:          res = a;
            OP_CLZ:           res = lead_run(a, 1'b0);
            OP_CLO:           res = lead_run(a, 1'b1);
            OP_MFC0, OP_MTC0: res = cp0_read(u.cp0_addr);
            default:          res = u.pc + 32'd8;
        endcase
        case (u.op)
            OP_BEQ:  taken = (a == b);
            OP_BNE:  taken = (a != b);
            OP_BGEZ: taken = ($signed(a) >= 0);
            OP_BGTZ: taken = ($signed(a) > 0);
            OP_BLEZ: taken = ($signed(a) <= 0);
            OP_BLTZ: taken = ($signed(a) < 0);
            OP_J, OP_JR, OP_JAL, OP_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
        if (u.op == OP_ADD) ovf = (a[31] == b[31]) && (res[31] != a[31]);
        if (u.op == OP_SUB) ovf = (a[31] != b[31]) && (res[31] != a[31]);
        code = (u.exc_in != EXC_NONE) ? u.exc_in : (ovf ? EXC_INT_OVERFLOW : EXC_NONE);
        e                = '0;
        e.due            = cyc + 3;
        e.wen            = u.dst_we && (code == EXC_NONE);
        e.dst            = u.dst;
        e.wdata          = res;
        e.fin.id         = u.id;
        e.fin.exc        = code;
        e.fin.bad_vaddr  = u.pc;
        e.fin.br.taken   = u.is_branch && taken;
        e.fin.br.target  = (u.op == OP_JR || u.op == OP_JALR) ? a : u.pred_addr;
        e.exc            = (code != EXC_NONE);
        exp_q.push_back(e);
        if (e.wen) arch[u.dst] = res;
        if (u.op == OP_MTC0 && u.cp0_addr == `CP0_STATUS) m_status = a;
        if (u.op == OP_MTC0 && u.cp0_addr == `CP0_EPC) m_epc = a;
        if (e.exc) begin
            m_cause    = code;
            m_epc      = u.pc;
            m_badvaddr = u.pc;
        end
        prev_fault = e.exc;
    endtask

    task automatic load_imm(input preg_t d, input word_t v);
        issue(mk(OP_ADDU, 5'd0, 5'd0, d, v, 1'b1));
    endtask

    task automatic cp0_op(input uop_e op, input preg_t r, input logic [4:0] addr);
        uop_t u;
        u          = mk(op, r, 5'd0, r, '0, 1'b1);
        u.cp0_addr = addr;
        issue(u);
    endtask

    initial begin
        #(((N_RAND + N_DIRECTED) * 3 + 100) * T_CLK);
        $display("watchdog expired before the tests completed");
        fail_run();
    end

    initial begin
        uop_t u;
        uop_e bops [12];
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        issue_uop_i   = '0;
        exp_now       = '0;
        exp_valid     = 1'b0;
        cyc           = 0;
        uid           = 0;
        pc_next       = 32'h0040_0000;
        seed          = 32'h7b32ffe7;
        prev_fault    = 1'b0;
        m_status      = '0;
        m_epc         = '0;
        m_badvaddr    = '0;
        m_cause       = EXC_NONE;
        for (int i = 0; i < `EXU_PREGS; i++) arch[i] = '0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // random operands and ops
        for (int i = 1; i < `EXU_PREGS; i++) load_imm(preg_t'(i), lcg_next());
        for (int i = 0; i < N_RAND; i++) begin
            issue(mk(uop_e'(lcg_next() % 18), preg_t'(lcg_next() % 32),
                     preg_t'(lcg_next() % 32), preg_t'(1 + lcg_next() % 31),
                     lcg_next(), lcg_next() % 2 == 0));
            if (lcg_next() % 4 == 0) idle(1);
        end

        // dependency distance 1, 2 and 3
        for (int d = 1; d <= 3; d++) begin
            idle(3);
            load_imm(5'd10, lcg_next());
            idle(d - 1);
            issue(mk(OP_ADDU, 5'd10, 5'd10, 5'd11, '0, 1'b0));
        end
        for (int i = 0; i < 8; i++) issue(mk(OP_ADDU, 5'd12, 5'd11, 5'd12, '0, 1'b0));

        // leading zero and one counts
        load_imm(5'd20, 32'h0);
        load_imm(5'd21, 32'hffff_ffff);
        load_imm(5'd22, lcg_next());
        load_imm(5'd23, 32'h0000_8000);
        for (int r = 20; r <= 23; r++) begin
            issue(mk(OP_CLZ, preg_t'(r), 5'd0, 5'd24, '0, 1'b1));
            issue(mk(OP_CLO, preg_t'(r), 5'd0, 5'd25, '0, 1'b1));
        end

        // branches and jumps
        bops = '{OP_BEQ, OP_BNE, OP_BGEZ, OP_BGTZ, OP_BLEZ, OP_BLTZ,
                 OP_J, OP_JR, OP_JAL, OP_JALR, OP_BEQ, OP_BNE};
        load_imm(5'd1, 32'd5);
        load_imm(5'd2, 32'd5);
        load_imm(5'd3, 32'hffff_fffd);
        load_imm(5'd4, 32'd0);
        for (int s = 1; s <= 4; s++) begin
            for (int k = 0; k < 12; k++) issue(mk(bops[k], preg_t'(s), 5'd2, 5'd31, '0, 1'b0));
        end

        // overflow, kill and cp0 capture
        idle(2);
        load_imm(5'd1, 32'h7fff_ffff);
        load_imm(5'd2, 32'd1);
        load_imm(5'd8, 32'h8000_0000);
        issue(mk(OP_ADD, 5'd1, 5'd2, 5'd3, '0, 1'b0));
        issue(mk(OP_ADDU, 5'd1, 5'd2, 5'd4, '0, 1'b0));
        idle(1);
        cp0_op(OP_MFC0, 5'd5, `CP0_EPC);
        cp0_op(OP_MFC0, 5'd6, `CP0_BADVADDR);
        cp0_op(OP_MFC0, 5'd7, `CP0_CAUSE);
        issue(mk(OP_SUB, 5'd8, 5'd2, 5'd9, '0, 1'b0));
        issue(mk(OP_OR, 5'd8, 5'd2, 5'd9, '0, 1'b0));
        idle(1);
        u        = mk(OP_OR, 5'd1, 5'd2, 5'd9, '0, 1'b0);
        u.exc_in = EXC_RESERVED;
        issue(u);
        idle(1);
        cp0_op(OP_MFC0, 5'd7, `CP0_CAUSE);

        // mtc0 and mfc0
        load_imm(5'd10, lcg_next());
        cp0_op(OP_MTC0, 5'd10, `CP0_EPC);
        cp0_op(OP_MFC0, 5'd11, `CP0_EPC);
        cp0_op(OP_MTC0, 5'd10, `CP0_CAUSE);
        cp0_op(OP_MFC0, 5'd12, `CP0_CAUSE);
        cp0_op(OP_MTC0, 5'd10, `CP0_STATUS);
        cp0_op(OP_MFC0, 5'd13, `CP0_STATUS);

        idle(6);
        if (exp_q.size() != 0) begin
            $display("expected records were never checked");
            fail_run();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
